/* Bender.yml */
package:
  name: fp_addsub

export_include_dirs:
  - hdl

sources:
  # RTL in compile order
  - include_dirs:
      - hdl
    files:
      - hdl/fp_arith_pkg.sv
      - hdl/split_addsub.sv
      - hdl/redundant_accumulator.sv
      - hdl/redundant_normalize.sv
      - hdl/fp_addsub_unit.sv

  # Testbench
  - target: test
    include_dirs:
      - hdl
    files:
      - test/fp_addsub_tb.sv

/* fp_addsub.f */
+incdir+hdl
hdl/fp_arith_pkg.sv
hdl/split_addsub.sv
hdl/redundant_accumulator.sv
hdl/redundant_normalize.sv
hdl/fp_addsub_unit.sv
test/fp_addsub_tb.sv

/* hdl/fp_addsub_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_addsub_unit (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         in_valid,
    input  wire fp_arith_pkg::op_e      op,
    input  wire fp_arith_pkg::uint_fp_t x,
    input  wire fp_arith_pkg::uint_fp_t y,
    output fp_arith_pkg::uint_fp_t      sum,
    output logic                        carry,
    output logic                        sum_valid,
    output fp_arith_pkg::acc_int_t      acc_value,
    output logic                        acc_valid
);

    import fp_arith_pkg::*;

    logic            as_start;
    logic            as_sub;
    logic            acc_update;
    logic            acc_sub;
    logic            acc_clear;
    logic            norm_start;
    redundant_poly_t acc_q;

    ////////////////////
    // Opcode decode
    ////////////////////

    always_comb begin
        as_start   = 1'b0;
        as_sub     = 1'b0;
        acc_update = 1'b0;
        acc_sub    = 1'b0;
        acc_clear  = 1'b0;
        norm_start = 1'b0;
        case (op)
            op_add: begin
                as_start = in_valid;
            end
            op_sub: begin
                as_start = in_valid;
                as_sub   = 1'b1;
            end
            op_acc_add: begin
                acc_update = in_valid;
            end
            op_acc_sub: begin
                acc_update = in_valid;
                acc_sub    = 1'b1;
            end
            op_acc_clear: begin
                acc_clear = in_valid;
            end
            op_acc_read: begin
                norm_start = in_valid;
            end
            default: begin
            end
        endcase
    end

    ////////////////////
    // Datapath blocks
    ////////////////////

    split_addsub u_addsub (
        .clk   (clk),
        .rst_n (rst_n),
        .start (as_start),
        .sub   (as_sub),
        .x     (x),
        .y     (y),
        .sum   (sum),
        .carry (carry),
        .done  (sum_valid)
    );

    // Only x feeds the accumulator
    redundant_accumulator u_acc (
        .clk    (clk),
        .rst_n  (rst_n),
        .update (acc_update),
        .sub    (acc_sub),
        .clear  (acc_clear),
        .x      (x),
        .acc    (acc_q)
    );

    redundant_normalize u_norm (
        .clk   (clk),
        .rst_n (rst_n),
        .start (norm_start),
        .din   (acc_q),
        .dout  (acc_value),
        .done  (acc_valid)
    );

endmodule

`default_nettype wire

/* hdl/fp_arith_consts.svh */
`ifndef FP_ARITH_CONSTS_SVH
`define FP_ARITH_CONSTS_SVH

////////////////////
// Operand geometry
////////////////////

// Full operand width in bits
`define FP_WIDTH 256

// Number of limbs the operand is split into
`define LIMB_COUNT 4

// Value bits per limb
`define LIMB_WIDTH (`FP_WIDTH / `LIMB_COUNT)

// Signed carry bits held next to each limb
`define LIMB_CARRY 4

`endif

/* hdl/fp_arith_pkg.sv */
`default_nettype none

`include "fp_arith_consts.svh"

package fp_arith_pkg;

    ////////////////////
    // Data types
    ////////////////////

    typedef logic [`FP_WIDTH-1:0] uint_fp_t;

    typedef logic [`LIMB_WIDTH-1:0] limb_t;

    typedef logic signed [`LIMB_CARRY-1:0] limb_carry_t;

    // val weighs at the limb position, carry one limb higher
    typedef struct packed {
        limb_carry_t carry;
        limb_t       val;
    } redundant_limb_t;

    // Index 0 is the least significant limb
    typedef redundant_limb_t [`LIMB_COUNT-1:0] redundant_poly_t;

    // Two's complement, read modulo 2**260
    typedef logic [`FP_WIDTH+`LIMB_CARRY-1:0] acc_int_t;

    ////////////////////
    // Command opcodes
    ////////////////////

    typedef enum logic [2:0] {
        op_add       = 3'd0,
        op_sub       = 3'd1,
        op_acc_add   = 3'd2,
        op_acc_sub   = 3'd3,
        op_acc_clear = 3'd4,
        op_acc_read  = 3'd5
    } op_e;

endpackage

`default_nettype wire

/* hdl/redundant_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp_arith_consts.svh"

module redundant_accumulator (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         update,
    input  wire                         sub,
    input  wire                         clear,
    input  wire fp_arith_pkg::uint_fp_t x,
    output fp_arith_pkg::redundant_poly_t acc
);

    import fp_arith_pkg::*;

    localparam int LW  = `LIMB_WIDTH;
    localparam int LC  = `LIMB_CARRY;
    localparam int NL  = `LIMB_COUNT;
    localparam int PAD = 3;
    localparam int SW  = LW + PAD;

    redundant_poly_t    acc_next;
    logic [SW-1:0]      carry_in  [NL];
    logic signed [SW-1:0] limb_sum [NL];
    logic signed [SW-1:0] limb_ovf [NL];

    ////////////////////
    // Next value
    ////////////////////

    always_comb begin
        // Lowest limb has nothing below it
        carry_in[0] = '0;
        for (int i = 1; i < NL; i++) begin
            carry_in[i] = {{(SW-LC){acc[i-1].carry[LC-1]}}, acc[i-1].carry};
        end

        for (int i = 0; i < NL; i++) begin
            if (sub) begin
                limb_sum[i] = {{PAD{1'b0}}, acc[i].val}
                              - {{PAD{1'b0}}, x[i*LW +: LW]}
                              + carry_in[i];
            end else begin
                limb_sum[i] = {{PAD{1'b0}}, acc[i].val}
                              + {{PAD{1'b0}}, x[i*LW +: LW]}
                              + carry_in[i];
            end
            // Overflow lands in -1..1 for the lower limbs
            limb_ovf[i]       = limb_sum[i] >>> LW;
            acc_next[i].val   = limb_sum[i][LW-1:0];
            acc_next[i].carry = limb_ovf[i][LC-1:0];
        end

        // Top limb folds its overflow into its own carry, wraps in 4 bits
        acc_next[NL-1].carry = acc[NL-1].carry + limb_ovf[NL-1][LC-1:0];
    end

    ////////////////////
    // Register
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            acc <= '0;
        end else if (update) begin
            acc <= acc_next;
        end
    end

endmodule

`default_nettype wire

/* hdl/redundant_normalize.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp_arith_consts.svh"

module redundant_normalize (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           start,
    input  wire fp_arith_pkg::redundant_poly_t din,
    output fp_arith_pkg::acc_int_t        dout,
    output logic                          done
);

    import fp_arith_pkg::*;

    localparam int LW = `LIMB_WIDTH;
    localparam int LC = `LIMB_CARRY;
    localparam int TW = LW + LC;

    logic          sign0;
    logic          sign1;
    limb_t         c0_ext;
    limb_t         c1_ext;
    logic [TW-1:0] c2_ext;

    limb_t         r1_l0;
    limb_t         r1_l1;
    limb_t         r1_l2;
    logic [TW-1:0] r1_l3;
    logic          r1_k1;
    logic          r1_k2;
    logic          r1_s0;
    logic          r1_s1;

    limb_t         r2_l0;
    limb_t         r2_l1;
    limb_t         r2_l2;
    logic [TW-1:0] r2_l3;
    logic          r2_k2;
    logic          r2_s0;

    limb_t         r3_l0;
    limb_t         r3_l1;
    limb_t         r3_l2;
    logic [TW-1:0] r3_l3;

    logic          v1;
    logic          v2;

    assign sign0 = din[0].carry[LC-1];
    assign sign1 = din[1].carry[LC-1];

    // Carries sign-extended only as far as the receiving limb
    assign c0_ext = {{(LW-LC){sign0}}, din[0].carry};
    assign c1_ext = {{(LW-LC){sign1}}, din[1].carry};
    assign c2_ext = {{(TW-LC){din[2].carry[LC-1]}}, din[2].carry};

    ////////////////////
    // Stage 1
    ////////////////////

    // Every carry field moves one limb up, top limb grows to TW bits
    always_ff @(posedge clk) begin
        r1_l0          <= din[0].val;
        {r1_k1, r1_l1} <= {1'b0, din[1].val} + {1'b0, c0_ext};
        {r1_k2, r1_l2} <= {1'b0, din[2].val} + {1'b0, c1_ext};
        r1_l3          <= {din[3].carry, din[3].val} + c2_ext;
        r1_s0          <= sign0;
        r1_s1          <= sign1;
    end

    ////////////////////
    // Stage 2
    ////////////////////

    // Limb 1 is settled, limbs 2 and 3 take one-bit carries and pads
    always_ff @(posedge clk) begin
        r2_l0          <= r1_l0;
        r2_l1          <= r1_l1;
        {r2_k2, r2_l2} <= {1'b0, r1_l2} + {{LW{1'b0}}, r1_k1} + {1'b0, {LW{r1_s0}}};
        r2_l3          <= r1_l3 + {{(TW-1){1'b0}}, r1_k2} + {TW{r1_s1}};
        r2_s0          <= r1_s0;
    end

    ////////////////////
    // Stage 3
    ////////////////////

    // Only the top limb is still open
    always_ff @(posedge clk) begin
        r3_l0 <= r2_l0;
        r3_l1 <= r2_l1;
        r3_l2 <= r2_l2;
        r3_l3 <= r2_l3 + {{(TW-1){1'b0}}, r2_k2} + {TW{r2_s0}};
    end

    assign dout = {r3_l3, r3_l2, r3_l1, r3_l0};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1   <= 1'b0;
            v2   <= 1'b0;
            done <= 1'b0;
        end else begin
            v1   <= start;
            v2   <= v1;
            done <= v2;
        end
    end

endmodule

`default_nettype wire

/* hdl/split_addsub.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp_arith_consts.svh"

module split_addsub (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire                         sub,
    input  wire fp_arith_pkg::uint_fp_t x,
    input  wire fp_arith_pkg::uint_fp_t y,
    output fp_arith_pkg::uint_fp_t      sum,
    output logic                        carry,
    output logic                        done
);

    import fp_arith_pkg::*;

    localparam int QW = `LIMB_WIDTH;
    localparam int HW = 2 * `LIMB_WIDTH;

    uint_fp_t    y_eff;
    logic [QW:0] q0;
    logic [QW:0] q1;
    logic [QW:0] q2;
    logic [QW:0] q3;
    logic [HW:0] h_lo;
    logic [HW:0] h_hi;
    logic        v1;
    logic        v2;

    // Subtract as x + ~y + 1
    assign y_eff = sub ? ~y : y;

    ////////////////////
    // Stage 1
    ////////////////////

    // Quarters add independently, each keeps its carry bit
    always_ff @(posedge clk) begin
        q0 <= {1'b0, x[QW-1:0]} + {1'b0, y_eff[QW-1:0]} + {{QW{1'b0}}, sub};
        q1 <= {1'b0, x[2*QW-1:QW]} + {1'b0, y_eff[2*QW-1:QW]};
        q2 <= {1'b0, x[3*QW-1:2*QW]} + {1'b0, y_eff[3*QW-1:2*QW]};
        q3 <= {1'b0, x[4*QW-1:3*QW]} + {1'b0, y_eff[4*QW-1:3*QW]};
    end

    ////////////////////
    // Stage 2
    ////////////////////

    // Join quarter pairs into halves
    always_ff @(posedge clk) begin
        h_lo <= {q1 + {{QW{1'b0}}, q0[QW]}, q0[QW-1:0]};
        h_hi <= {q3 + {{QW{1'b0}}, q2[QW]}, q2[QW-1:0]};
    end

    ////////////////////
    // Stage 3
    ////////////////////

    // Low half carry into the high half, top bit is carry out
    always_ff @(posedge clk) begin
        {carry, sum} <= {h_hi + {{HW{1'b0}}, h_lo[HW]}, h_lo[HW-1:0]};
    end

    // Valid follows the data through the three stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1   <= 1'b0;
            v2   <= 1'b0;
            done <= 1'b0;
        end else begin
            v1   <= start;
            v2   <= v1;
            done <= v2;
        end
    end

endmodule

`default_nettype wire

/* test/fp_addsub_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp_arith_consts.svh"

module fp_addsub_tb;

    import fp_arith_pkg::*;

    localparam int RESET_CYCLES  = 8;
    localparam int IDLE_CYCLES   = 4;
    localparam int RAND_PAIRS    = 40;
    localparam int ONES_RUN      = 20;
    localparam int ACC_BLOCKS    = 4;
    localparam int ACC_BLOCK_LEN = 16;
    localparam int MIX_CMDS      = 200;

    // One read, add and sub phases, accumulate phase, clear/order phase, mixed
    localparam int TOTAL_CMDS = 1 + (RAND_PAIRS + 3) + (RAND_PAIRS + 4)
                              + (2 + ONES_RUN + ACC_BLOCKS * (ACC_BLOCK_LEN + 1))
                              + 7 + MIX_CMDS;
    localparam int TIMEOUT_CYCLES = TOTAL_CMDS + RESET_CYCLES + IDLE_CYCLES + 20;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_valid;
    op_e      op;
    uint_fp_t x;
    uint_fp_t y;
    uint_fp_t sum;
    logic     carry;
    logic     sum_valid;
    acc_int_t acc_value;
    logic     acc_valid;

    int          cycle = 0;
    logic [31:0] lcg_state = 32'ha4ea;
    acc_int_t    acc_model = '0;

    // Expected results stamped with the negedge count they are due on
    uint_fp_t sum_exp_q[$];
    logic     carry_exp_q[$];
    int       sum_due_q[$];
    string    sum_name_q[$];
    acc_int_t acc_exp_q[$];
    int       acc_due_q[$];
    string    acc_name_q[$];

    fp_addsub_unit uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .x         (x),
        .y         (y),
        .sum       (sum),
        .carry     (carry),
        .sum_valid (sum_valid),
        .acc_value (acc_value),
        .acc_valid (acc_valid)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Random numbers
    ////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Eight draws per operand
    function automatic uint_fp_t random_wide();
        uint_fp_t v;
        for (int i = 0; i < `FP_WIDTH / 32; i++) begin
            v[i*32 +: 32] = lcg_next();
        end
        return v;
    endfunction

    // Bias toward all-ones and zero to stress carries
    function automatic uint_fp_t pick_operand();
        logic [31:0] r;
        r = lcg_next();
        case (r[31:29])
            3'd0:    return '1;
            3'd1:    return '0;
            default: return random_wide();
        endcase
    endfunction

    function automatic op_e pick_op();
        logic [31:0] r;
        r = lcg_next();
        case (r[31:16] % 6)
            0:       return op_add;
            1:       return op_sub;
            2:       return op_acc_add;
            3:       return op_acc_sub;
            4:       return op_acc_clear;
            default: return op_acc_read;
        endcase
    endfunction

    ////////////////////
    // Failure handling
    ////////////////////

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_sum(input string name, input uint_fp_t exp_sum, input logic exp_carry,
                             input uint_fp_t act_sum, input logic act_carry);
        if (act_sum !== exp_sum || act_carry !== exp_carry) begin
            $display("** Error: %s: expected sum %h carry %b, actual sum %h carry %b",
                     name, exp_sum, exp_carry, act_sum, act_carry);
            stop_run();
        end
    endtask

    task automatic check_acc(input string name, input acc_int_t exp_val, input acc_int_t act_val);
        if (act_val !== exp_val) begin
            $display("** Error: %s: expected acc_value %h, actual acc_value %h",
                     name, exp_val, act_val);
            stop_run();
        end
    endtask

    ////////////////////
    // Command driver and model
    ////////////////////

    task automatic issue_cmd(input op_e cmd, input uint_fp_t a, input uint_fp_t b,
                             input string name);
        int                 due;
        logic [`FP_WIDTH:0] wide;
        @(posedge clk);
        in_valid <= 1'b1;
        op       <= cmd;
        x        <= a;
        y        <= b;
        // DUT samples on the next edge, result shows three edges later
        due = cycle + 4;
        case (cmd)
            op_add: begin
                wide = {1'b0, a} + {1'b0, b};
                sum_exp_q.push_back(wide[`FP_WIDTH-1:0]);
                carry_exp_q.push_back(wide[`FP_WIDTH]);
                sum_due_q.push_back(due);
                sum_name_q.push_back(name);
            end
            op_sub: begin
                sum_exp_q.push_back(a - b);
                carry_exp_q.push_back(a >= b);
                sum_due_q.push_back(due);
                sum_name_q.push_back(name);
            end
            op_acc_add: begin
                acc_model = acc_model + {{`LIMB_CARRY{1'b0}}, a};
            end
            op_acc_sub: begin
                acc_model = acc_model - {{`LIMB_CARRY{1'b0}}, a};
            end
            op_acc_clear: begin
                acc_model = '0;
            end
            default: begin
                acc_exp_q.push_back(acc_model);
                acc_due_q.push_back(due);
                acc_name_q.push_back(name);
            end
        endcase
    endtask

    // Strobe held low while a live opcode sits on the bus
    task automatic idle_cycle(input op_e cmd, input uint_fp_t a);
        @(posedge clk);
        in_valid <= 1'b0;
        op       <= cmd;
        x        <= a;
        y        <= a;
    endtask

    ////////////////////
    // Output monitor
    ////////////////////

    task automatic watch_sum();
        if (sum_valid !== 1'b0 && sum_valid !== 1'b1) begin
            report_failure("sum_valid is unknown");
        end else if (sum_valid) begin
            if (sum_due_q.size() == 0) begin
                report_failure("sum_valid pulsed with no add or subtract pending");
            end else if (sum_due_q[0] != cycle) begin
                report_failure($sformatf("sum_valid pulsed on cycle %0d, expected on %0d",
                                         cycle, sum_due_q[0]));
            end else begin
                check_sum(sum_name_q[0], sum_exp_q[0], carry_exp_q[0], sum, carry);
                void'(sum_exp_q.pop_front());
                void'(carry_exp_q.pop_front());
                void'(sum_due_q.pop_front());
                void'(sum_name_q.pop_front());
            end
        end else if (sum_due_q.size() != 0 && sum_due_q[0] <= cycle) begin
            report_failure($sformatf("sum_valid did not pulse on cycle %0d", sum_due_q[0]));
        end
    endtask

    task automatic watch_acc();
        if (acc_valid !== 1'b0 && acc_valid !== 1'b1) begin
            report_failure("acc_valid is unknown");
        end else if (acc_valid) begin
            if (acc_due_q.size() == 0) begin
                report_failure("acc_valid pulsed with no read pending");
            end else if (acc_due_q[0] != cycle) begin
                report_failure($sformatf("acc_valid pulsed on cycle %0d, expected on %0d",
                                         cycle, acc_due_q[0]));
            end else begin
                check_acc(acc_name_q[0], acc_exp_q[0], acc_value);
                void'(acc_exp_q.pop_front());
                void'(acc_due_q.pop_front());
                void'(acc_name_q.pop_front());
            end
        end else if (acc_due_q.size() != 0 && acc_due_q[0] <= cycle) begin
            report_failure($sformatf("acc_valid did not pulse on cycle %0d", acc_due_q[0]));
        end
    endtask

    // Outputs settle long before the falling edge
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles", cycle));
        end else begin
            watch_sum();
            watch_acc();
        end
    end

    ////////////////////
    // Test phases
    ////////////////////

    task automatic reset_read();
        issue_cmd(op_acc_read, '0, '0, "reset_read");
    endtask

    task automatic add_cases();
        for (int i = 0; i < RAND_PAIRS; i++) begin
            issue_cmd(op_add, random_wide(), random_wide(), "add_random");
        end
        issue_cmd(op_add, '1, '1, "add_all_ones");
        issue_cmd(op_add, '1, 1, "add_ripple");
        issue_cmd(op_add, '0, '0, "add_zero");
    endtask

    task automatic sub_cases();
        uint_fp_t a;
        for (int i = 0; i < RAND_PAIRS; i++) begin
            issue_cmd(op_sub, random_wide(), random_wide(), "sub_random");
        end
        a = random_wide();
        issue_cmd(op_sub, a, a, "sub_equal");
        a = random_wide() >> 1;
        issue_cmd(op_sub, a, a + 1, "sub_less");
        issue_cmd(op_sub, '0, random_wide(), "sub_zero_x");
        issue_cmd(op_sub, '0, '0, "sub_zero_both");
    endtask

    // More than 16 all-ones adds wrap the top carry field
    task automatic accumulate_runs();
        logic [31:0] r;
        issue_cmd(op_acc_clear, '0, '0, "acc_clear");
        for (int i = 0; i < ONES_RUN; i++) begin
            issue_cmd(op_acc_add, '1, '0, "acc_ones");
        end
        issue_cmd(op_acc_read, '0, '0, "acc_ones_read");
        for (int b = 0; b < ACC_BLOCKS; b++) begin
            for (int i = 0; i < ACC_BLOCK_LEN; i++) begin
                r = lcg_next();
                issue_cmd(r[31] ? op_acc_sub : op_acc_add, pick_operand(), '0, "acc_run");
            end
            issue_cmd(op_acc_read, '0, '0, "acc_run_read");
        end
    endtask

    task automatic clear_and_order();
        issue_cmd(op_acc_add, random_wide(), '0, "order_fill");
        issue_cmd(op_acc_clear, '0, '0, "order_clear");
        issue_cmd(op_acc_read, '0, '0, "clear_then_read");
        issue_cmd(op_acc_add, random_wide(), '0, "order_add");
        issue_cmd(op_acc_read, '0, '0, "read_after_add");
        issue_cmd(op_acc_sub, random_wide(), '0, "order_sub");
        issue_cmd(op_acc_read, '0, '0, "read_after_sub");
    endtask

    // Some cycles drop the strobe so no opcode may act on its own
    task automatic mixed_traffic();
        logic [31:0] r;
        for (int i = 0; i < MIX_CMDS; i++) begin
            r = lcg_next();
            if (r[31:29] == 3'd0) begin
                idle_cycle(pick_op(), pick_operand());
            end else begin
                issue_cmd(pick_op(), pick_operand(), pick_operand(), "mixed");
            end
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        op       = op_add;
        x        = '0;
        y        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);

        reset_read();
        add_cases();
        sub_cases();
        accumulate_runs();
        clear_and_order();
        mixed_traffic();

        @(posedge clk);
        in_valid <= 1'b0;
        // Drain both pipelines, then watch a few quiet cycles
        while (sum_due_q.size() != 0 || acc_due_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
